// File: source/touch_pkg.sv
// shared definitions for the MPR121 touch controller
// register map, setup table, host opcodes, sequencer states and bus structs
`default_nettype none

package touch_pkg;

	// ================================================
	// widths
	// ================================================
	localparam int BYTE_W  = 8;  // register addr and data
	localparam int TOUCH_W = 12; // one bit per electrode
	localparam int FRAME_W = 32; // host frame

	// ================================================
	// MPR121 register map
	// ================================================
	localparam logic [BYTE_W-1:0] REG_TOUCH_0    = 8'h00; // ele 0..7
	localparam logic [BYTE_W-1:0] REG_TOUCH_1    = 8'h01; // ele 8..11 in low nibble
	localparam logic [BYTE_W-1:0] REG_ELE_CONFIG = 8'h5E;
	localparam logic [BYTE_W-1:0] ELE_RUN        = 8'h8F; // all 12 electrodes on
	localparam logic [BYTE_W-1:0] ELE_STOP       = 8'h00; // back to stop mode

	// setup table, written in order once the bridge is up
	localparam int SETUP_LEN   = 14;
	localparam int SETUP_IDX_W = $clog2(SETUP_LEN);
	localparam logic [SETUP_IDX_W-1:0] SETUP_LAST = SETUP_IDX_W'(SETUP_LEN - 1);

	localparam logic [BYTE_W-1:0] SETUP_ADDR [SETUP_LEN] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, // rising baseline filter
		8'h2F, 8'h30, 8'h31, 8'h32, // falling baseline filter
		8'h33, 8'h34, 8'h35,        // touched baseline filter
		8'h5B, 8'h5C, 8'h5D         // debounce, cdc and cdt config
	};
	localparam logic [BYTE_W-1:0] SETUP_DATA [SETUP_LEN] = '{
		8'h01, 8'h01, 8'h0E, 8'h00,
		8'h01, 8'h05, 8'h01, 8'h00,
		8'h00, 8'h00, 8'h00,
		8'h00, 8'h10, 8'h20
	};

	// frame tags, first byte of every host frame
	localparam logic [BYTE_W-1:0] TAG_TOUCH = 8'hBB; // touch status
	localparam logic [BYTE_W-1:0] TAG_REG   = 8'h6D; // register reply

	// ================================================
	// enums
	// ================================================
	typedef enum logic [BYTE_W-1:0] {
		OP_RUN      = 8'h52, // 'R'
		OP_STOP     = 8'h53, // 'S'
		OP_READ_REG = 8'h6D  // 'm', arg is the register
	} host_op_e;

	typedef enum logic {
		XFER_WRITE = 1'b0,
		XFER_READ  = 1'b1
	} xfer_op_e;

	typedef enum logic [3:0] {
		S_WAIT_INIT,   // bridge not ready yet
		S_SETUP_WAIT,  // one setup write in flight
		S_STANDBY,     // idle, chip configured
		S_RUN_WAIT,    // ELE_RUN write
		S_STOP_WAIT,   // ELE_STOP write
		S_POLL_0,      // run check before each status pair
		S_POLL_0_WAIT, // reading touch 0
		S_POLL_1_WAIT, // reading touch 1
		S_READ_WAIT,   // host register read
		S_READ_END     // lets the pending flag drop
	} seq_state_e;

	// ================================================
	// structs
	// ================================================
	typedef struct packed {
		host_op_e          op;
		logic [BYTE_W-1:0] arg;
	} rx_word_t;

	typedef struct packed {
		xfer_op_e          op;
		logic [BYTE_W-1:0] addr;
		logic [BYTE_W-1:0] data; // don't care on reads
	} xfer_cmd_t;

	typedef struct packed {
		logic              wr_en; // one-cycle pulse
		logic              rd_en; // one-cycle pulse
		logic [BYTE_W-1:0] addr;
		logic [BYTE_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic              busy;
		logic              fail;  // valid with busy low
		logic [BYTE_W-1:0] rdata;
	} bus_rsp_t;

	typedef struct packed {
		logic [BYTE_W-1:0]         tag;
		logic [FRAME_W-BYTE_W-1:0] payload;
	} tx_frame_t;

endpackage

`default_nettype wire

// File: source/host_cmd_regs.sv
// host command block beside the sequencer
// decodes 16-bit host words into the run mode and a pending register read
`timescale 1ns/1ps
`default_nettype none

module host_cmd_regs (
	input  logic                         i_CLK,
	input  logic                         i_RST,
	input  touch_pkg::rx_word_t          i_rx,
	input  logic                         i_rx_valid,  // one-cycle, no back-pressure
	input  logic                         i_read_done, // sequencer finished the read
	output logic                         o_run_mode,
	output logic                         o_read_pending,
	output logic [touch_pkg::BYTE_W-1:0] o_read_addr
);

	logic w_read_req; // read request that is taken this cycle

	// a second request while one is still open is dropped
	assign w_read_req = i_rx_valid && (i_rx.op == touch_pkg::OP_READ_REG) &&
		(!o_read_pending || i_read_done);

	// ================================================
	// mode and pending flags
	// ================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_run_mode     <= 1'b0;
			o_read_pending <= 1'b0;
		end else begin
			if (i_rx_valid) begin
				case (i_rx.op)
					touch_pkg::OP_RUN:  o_run_mode <= 1'b1;
					touch_pkg::OP_STOP: o_run_mode <= 1'b0;
					default: ; // read handled below, others ignored
				endcase
			end
			if (w_read_req)
				o_read_pending <= 1'b1;
			else if (i_read_done)
				o_read_pending <= 1'b0;
		end
	end

	// address held for the sequencer and the reply frame
	always_ff @(posedge i_CLK) begin
		if (w_read_req)
			o_read_addr <= i_rx.arg;
	end

endmodule

`default_nettype wire

// File: source/touch_xfer.sv
// one register write or read on the MPR121 bridge
// start with a command, wait for done, then read fail and rdata
`timescale 1ns/1ps
`default_nettype none

module touch_xfer (
	input  logic                         i_CLK,
	input  logic                         i_RST,
	input  logic                         i_start, // only taken while idle
	input  touch_pkg::xfer_cmd_t         i_cmd,
	input  touch_pkg::bus_rsp_t          i_bus_rsp,
	output touch_pkg::bus_req_t          o_bus_req,
	output logic                         o_done,  // one-cycle
	output logic                         o_fail,
	output logic [touch_pkg::BYTE_W-1:0] o_rdata
);

	typedef enum logic [1:0] {
		X_IDLE,   // waiting for start
		X_ENABLE, // addr and data on the bus
		X_PULSE,  // enable high for this cycle
		X_WAIT    // sampling busy
	} xfer_state_e;

	xfer_state_e                  r_state;
	touch_pkg::xfer_op_e          r_op;
	logic                         r_wr_en;
	logic                         r_rd_en;
	logic [touch_pkg::BYTE_W-1:0] r_addr;
	logic [touch_pkg::BYTE_W-1:0] r_wdata;
	logic                         w_end; // first idle busy after the pulse

	assign w_end = (r_state == X_WAIT) && !i_bus_rsp.busy;

	assign o_bus_req = '{wr_en: r_wr_en, rd_en: r_rd_en, addr: r_addr, wdata: r_wdata};

	// ================================================
	// control
	// ================================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state <= X_IDLE;
			r_wr_en <= 1'b0;
			r_rd_en <= 1'b0;
			o_done  <= 1'b0;
			o_fail  <= 1'b0;
		end else begin
			r_wr_en <= 1'b0; // enables are single pulses
			r_rd_en <= 1'b0;
			o_done  <= 1'b0;
			case (r_state)
				X_IDLE: begin
					if (i_start)
						r_state <= X_ENABLE;
				end
				X_ENABLE: begin
					r_wr_en <= (r_op == touch_pkg::XFER_WRITE);
					r_rd_en <= (r_op == touch_pkg::XFER_READ);
					r_state <= X_PULSE;
				end
				X_PULSE: r_state <= X_WAIT; // bridge raises busy meanwhile
				X_WAIT: begin
					if (w_end) begin
						o_done  <= 1'b1;
						o_fail  <= i_bus_rsp.fail;
						r_state <= X_IDLE;
					end
				end
				default: r_state <= X_IDLE;
			endcase
		end
	end

	// command and result payload
	always_ff @(posedge i_CLK) begin
		if (r_state == X_IDLE && i_start) begin
			r_op    <= i_cmd.op;
			r_addr  <= i_cmd.addr;
			r_wdata <= i_cmd.data;
		end
		if (w_end)
			o_rdata <= i_bus_rsp.rdata;
	end

endmodule

`default_nettype wire

// File: source/touch_sequencer.sv
// MPR121 sequencer, runs setup, run and stop writes, touch polling
// and single host register reads through touch_xfer, keeps the sticky flags
`timescale 1ns/1ps
`default_nettype none

module touch_sequencer (
	input  logic                          i_CLK,
	input  logic                          i_RST,
	input  logic                          i_init_set,     // bridge ready, level
	input  logic                          i_run_mode,
	input  logic                          i_read_pending,
	input  logic [touch_pkg::BYTE_W-1:0]  i_read_addr,
	input  logic                          i_xfer_done,
	input  logic                          i_xfer_fail,
	input  logic [touch_pkg::BYTE_W-1:0]  i_xfer_rdata,
	output logic                          o_xfer_start,
	output touch_pkg::xfer_cmd_t          o_xfer_cmd,
	output logic [touch_pkg::TOUCH_W-1:0] o_touch,
	output logic                          o_touch_valid,  // new vector offered
	output logic                          o_reg_reply_valid,
	output logic [touch_pkg::BYTE_W-1:0]  o_reg_reply_data,
	output logic                          o_read_done,    // clears the pending read
	output logic                          o_chip_set,     // sticky
	output logic                          o_run_set,
	output logic                          o_error         // sticky
);

	touch_pkg::seq_state_e             r_state;
	logic [touch_pkg::SETUP_IDX_W-1:0] r_idx;     // setup entry in flight
	logic [touch_pkg::BYTE_W-1:0]      r_touch_0; // first half of the vector

	function automatic touch_pkg::xfer_cmd_t mk_cmd(
		input touch_pkg::xfer_op_e          op_v,
		input logic [touch_pkg::BYTE_W-1:0] addr_v,
		input logic [touch_pkg::BYTE_W-1:0] data_v
	);
		mk_cmd = '{op: op_v, addr: addr_v, data: data_v};
	endfunction

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state           <= touch_pkg::S_WAIT_INIT;
			r_idx             <= '0;
			r_touch_0         <= '0;
			o_xfer_start      <= 1'b0;
			o_xfer_cmd        <= '0;
			o_touch           <= '0;
			o_touch_valid     <= 1'b0;
			o_reg_reply_valid <= 1'b0;
			o_reg_reply_data  <= '0;
			o_read_done       <= 1'b0;
			o_chip_set        <= 1'b0;
			o_run_set         <= 1'b0;
			o_error           <= 1'b0;
		end else begin
			o_xfer_start      <= 1'b0; // pulses
			o_touch_valid     <= 1'b0;
			o_reg_reply_valid <= 1'b0;
			o_read_done       <= 1'b0;

			// ================================================
			// failed transfer, drop the current operation
			// ================================================
			if (i_xfer_done && i_xfer_fail) begin
				o_error <= 1'b1;
				r_idx   <= '0;
				if (r_state == touch_pkg::S_READ_WAIT) begin
					o_read_done <= 1'b1; // no reply for this one
					r_state     <= touch_pkg::S_READ_END;
				end else if (o_chip_set)
					r_state <= touch_pkg::S_STANDBY;
				else
					r_state <= touch_pkg::S_WAIT_INIT; // setup starts over
			end else begin
				case (r_state)
					touch_pkg::S_WAIT_INIT: begin
						if (i_init_set) begin
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_WRITE,
								touch_pkg::SETUP_ADDR[0], touch_pkg::SETUP_DATA[0]);
							r_idx        <= '0;
							r_state      <= touch_pkg::S_SETUP_WAIT;
						end
					end
					touch_pkg::S_SETUP_WAIT: begin
						if (i_xfer_done) begin
							if (r_idx == touch_pkg::SETUP_LAST) begin
								o_chip_set <= 1'b1; // stays set until reset
								r_state    <= touch_pkg::S_STANDBY;
							end else begin
								o_xfer_start <= 1'b1;
								o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_WRITE,
									touch_pkg::SETUP_ADDR[r_idx + 1'b1],
									touch_pkg::SETUP_DATA[r_idx + 1'b1]);
								r_idx        <= r_idx + 1'b1;
							end
						end
					end

					// ================================================
					// standby, run and stop
					// ================================================
					touch_pkg::S_STANDBY: begin
						if (i_run_mode) begin
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_WRITE,
								touch_pkg::REG_ELE_CONFIG, touch_pkg::ELE_RUN);
							r_state      <= touch_pkg::S_RUN_WAIT;
						end else if (o_run_set) begin // still running, stop it
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_WRITE,
								touch_pkg::REG_ELE_CONFIG, touch_pkg::ELE_STOP);
							r_state      <= touch_pkg::S_STOP_WAIT;
						end else if (i_read_pending) begin
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_READ, i_read_addr, '0);
							r_state      <= touch_pkg::S_READ_WAIT;
						end
					end
					touch_pkg::S_RUN_WAIT: begin
						if (i_xfer_done) begin
							o_run_set <= 1'b1;
							r_state   <= touch_pkg::S_POLL_0;
						end
					end
					touch_pkg::S_STOP_WAIT: begin
						if (i_xfer_done) begin
							o_run_set <= 1'b0;
							r_state   <= touch_pkg::S_STANDBY;
						end
					end

					// ================================================
					// status polling
					// ================================================
					touch_pkg::S_POLL_0: begin
						if (i_run_mode) begin
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_READ, touch_pkg::REG_TOUCH_0, '0);
							r_state      <= touch_pkg::S_POLL_0_WAIT;
						end else
							r_state <= touch_pkg::S_STANDBY; // standby writes ELE_STOP
					end
					touch_pkg::S_POLL_0_WAIT: begin
						if (i_xfer_done) begin
							r_touch_0    <= i_xfer_rdata;
							o_xfer_start <= 1'b1;
							o_xfer_cmd   <= mk_cmd(touch_pkg::XFER_READ, touch_pkg::REG_TOUCH_1, '0);
							r_state      <= touch_pkg::S_POLL_1_WAIT;
						end
					end
					touch_pkg::S_POLL_1_WAIT: begin
						if (i_xfer_done) begin
							o_touch       <= {i_xfer_rdata[3:0], r_touch_0};
							o_touch_valid <= 1'b1;
							r_state       <= touch_pkg::S_POLL_0;
						end
					end

					// host register read, reply and done together
					touch_pkg::S_READ_WAIT: begin
						if (i_xfer_done) begin
							o_reg_reply_data  <= i_xfer_rdata;
							o_reg_reply_valid <= 1'b1;
							o_read_done       <= 1'b1;
							r_state           <= touch_pkg::S_READ_END;
						end
					end
					touch_pkg::S_READ_END: r_state <= touch_pkg::S_STANDBY;
					default: r_state <= touch_pkg::S_WAIT_INIT;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: source/tx_framer.sv
// host transmit side, builds tagged 32-bit frames
// one slot per source, register reply first, frame held while ready is low
`timescale 1ns/1ps
`default_nettype none

module tx_framer (
	input  logic                          i_CLK,
	input  logic                          i_RST,
	input  logic [touch_pkg::TOUCH_W-1:0] i_touch,
	input  logic                          i_touch_valid,
	input  logic                          i_reg_reply_valid,
	input  logic [touch_pkg::BYTE_W-1:0]  i_reg_addr,
	input  logic [touch_pkg::BYTE_W-1:0]  i_reg_data,
	input  logic                          i_tx_ready,
	output touch_pkg::tx_frame_t          o_tx,
	output logic                          o_tx_valid
);

	logic                          r_touch_full; // touch slot waiting
	logic [touch_pkg::TOUCH_W-1:0] r_touch_vec;  // latest vector wins
	logic                          r_reg_full;   // reply slot waiting
	logic [touch_pkg::BYTE_W-1:0]  r_reg_addr;
	logic [touch_pkg::BYTE_W-1:0]  r_reg_data;
	logic                          w_load;       // output register free this cycle
	logic                          w_take_reg;
	logic                          w_take_touch;

	assign w_load       = !o_tx_valid || i_tx_ready;
	assign w_take_reg   = w_load && r_reg_full;
	assign w_take_touch = w_load && !r_reg_full && r_touch_full;

	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_tx_valid   <= 1'b0;
			r_touch_full <= 1'b0;
			r_reg_full   <= 1'b0;
		end else begin
			if (w_load)
				o_tx_valid <= r_reg_full || r_touch_full;
			if (i_reg_reply_valid) // a new arrival beats the clear
				r_reg_full <= 1'b1;
			else if (w_take_reg)
				r_reg_full <= 1'b0;
			if (i_touch_valid)
				r_touch_full <= 1'b1;
			else if (w_take_touch)
				r_touch_full <= 1'b0;
		end
	end

	// ================================================
	// slot contents and frame assembly
	// ================================================
	always_ff @(posedge i_CLK) begin
		if (i_reg_reply_valid) begin
			r_reg_addr <= i_reg_addr;
			r_reg_data <= i_reg_data;
		end
		if (i_touch_valid)
			r_touch_vec <= i_touch;
		if (w_take_reg)
			o_tx <= '{tag: touch_pkg::TAG_REG, payload: {r_reg_addr, r_reg_data, 8'h00}};
		else if (w_take_touch)
			o_tx <= '{tag: touch_pkg::TAG_TOUCH, payload: {4'h0, r_touch_vec, 8'h00}};
	end

endmodule

`default_nettype wire

// File: source/touch_top.sv
// top level of the MPR121 touch controller
// host command words in, tagged frames out, register bus to the sensor bridge
`timescale 1ns/1ps
`default_nettype none

module touch_top (
	input  logic                          i_CLK,
	input  logic                          i_RST,
	input  touch_pkg::rx_word_t           i_rx,
	input  logic                          i_rx_valid,
	input  logic                          i_tx_ready,
	input  touch_pkg::bus_rsp_t           i_bus_rsp,
	input  logic                          i_init_set,
	output touch_pkg::tx_frame_t          o_tx,
	output logic                          o_tx_valid,
	output touch_pkg::bus_req_t           o_bus_req,
	output logic [touch_pkg::TOUCH_W-1:0] o_touch,
	output logic                          o_chip_set,
	output logic                          o_run_set,
	output logic                          o_error
);

	// host command block
	logic                         w_run_mode;
	logic                         w_read_pending;
	logic [touch_pkg::BYTE_W-1:0] w_read_addr;   // also the reply address
	logic                         w_read_done;

	// sequencer to transfer engine
	logic                         w_xfer_start;
	touch_pkg::xfer_cmd_t         w_xfer_cmd;
	logic                         w_xfer_done;
	logic                         w_xfer_fail;
	logic [touch_pkg::BYTE_W-1:0] w_xfer_rdata;

	// sequencer to framer
	logic                         w_touch_valid;
	logic                         w_reply_valid;
	logic [touch_pkg::BYTE_W-1:0] w_reply_data;

	host_cmd_regs cmd_i (
		.i_CLK (i_CLK), .i_RST (i_RST),
		.i_rx (i_rx), .i_rx_valid (i_rx_valid), .i_read_done (w_read_done),
		.o_run_mode (w_run_mode), .o_read_pending (w_read_pending),
		.o_read_addr (w_read_addr)
	);

	touch_sequencer seq_i (
		.i_CLK (i_CLK), .i_RST (i_RST), .i_init_set (i_init_set),
		.i_run_mode (w_run_mode), .i_read_pending (w_read_pending),
		.i_read_addr (w_read_addr),
		.i_xfer_done (w_xfer_done), .i_xfer_fail (w_xfer_fail), .i_xfer_rdata (w_xfer_rdata),
		.o_xfer_start (w_xfer_start), .o_xfer_cmd (w_xfer_cmd),
		.o_touch (o_touch), .o_touch_valid (w_touch_valid),
		.o_reg_reply_valid (w_reply_valid), .o_reg_reply_data (w_reply_data),
		.o_read_done (w_read_done), .o_chip_set (o_chip_set),
		.o_run_set (o_run_set), .o_error (o_error)
	);

	touch_xfer xfer_i (
		.i_CLK (i_CLK), .i_RST (i_RST),
		.i_start (w_xfer_start), .i_cmd (w_xfer_cmd), .i_bus_rsp (i_bus_rsp),
		.o_bus_req (o_bus_req), .o_done (w_xfer_done),
		.o_fail (w_xfer_fail), .o_rdata (w_xfer_rdata)
	);

	tx_framer framer_i (
		.i_CLK (i_CLK), .i_RST (i_RST),
		.i_touch (o_touch), .i_touch_valid (w_touch_valid),
		.i_reg_reply_valid (w_reply_valid), .i_reg_addr (w_read_addr),
		.i_reg_data (w_reply_data), .i_tx_ready (i_tx_ready),
		.o_tx (o_tx), .o_tx_valid (o_tx_valid)
	);

endmodule

`default_nettype wire

// File: dv/touch_props.sv
// protocol assertions for the touch controller
// bound into every touch_top instance, checks host and bridge handshakes and the flags
`timescale 1ns/1ps
`default_nettype none

module touch_props (
	input logic                 i_CLK,
	input logic                 i_RST,
	input touch_pkg::tx_frame_t i_tx,
	input logic                 i_tx_valid,
	input logic                 i_tx_ready,
	input touch_pkg::bus_req_t  i_bus_req,
	input touch_pkg::bus_rsp_t  i_bus_rsp,
	input logic                 i_chip_set,
	input logic                 i_run_set
);

	logic w_en_any; // either bridge enable
	assign w_en_any = i_bus_req.wr_en || i_bus_req.rd_en;

	// ================================================
	// host transmit side
	// ================================================
	a_tx_hold: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_tx_valid && !i_tx_ready |=> i_tx_valid && $stable(i_tx))
		else $error("frame or valid changed while ready was low");

	// ================================================
	// bridge enables
	// ================================================
	a_en_pulse: assert property (@(posedge i_CLK) disable iff (i_RST)
		w_en_any |=> !w_en_any)
		else $error("bridge enable longer than one cycle");
	a_en_excl: assert property (@(posedge i_CLK) disable iff (i_RST)
		!(i_bus_req.wr_en && i_bus_req.rd_en))
		else $error("write and read enable high together");
	// busy may rise during the enable cycle, so look at the cycle before it
	a_en_idle: assert property (@(posedge i_CLK) disable iff (i_RST)
		w_en_any |-> !$past(i_bus_rsp.busy))
		else $error("enable given while the bridge was busy");

	// sticky and ordered status flags
	a_chip_sticky: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_chip_set |=> i_chip_set)
		else $error("chip set flag fell");
	a_run_chip: assert property (@(posedge i_CLK) disable iff (i_RST)
		i_run_set |-> i_chip_set)
		else $error("run set without chip set");

endmodule

bind touch_top touch_props props_i (
	.i_CLK (i_CLK), .i_RST (i_RST), .i_tx (o_tx), .i_tx_valid (o_tx_valid),
	.i_tx_ready (i_tx_ready), .i_bus_req (o_bus_req), .i_bus_rsp (i_bus_rsp),
	.i_chip_set (o_chip_set), .i_run_set (o_run_set)
);

`default_nettype wire

// File: dv/touch_tb.sv
// testbench for the MPR121 touch controller
// bridge model with random busy length, host commands, frame checks and a watchdog
// run through run.sh, checks are immediate assertions plus the bound touch_props
`timescale 1ns/1ps
`default_nettype none

module touch_tb;

	// ================================================
	// constants and signals
	// ================================================
	localparam int PLANNED_XFERS   = 80; // setup, run, stop, polls and reads
	localparam int WATCHDOG_CYCLES = PLANNED_XFERS * 6 + 2000;

	// setup writes as {addr, data}, in table order
	localparam logic [15:0] SETUP_WRITES [14] = '{
		16'h2B01, 16'h2C01, 16'h2D0E, 16'h2E00, 16'h2F01, 16'h3005, 16'h3101,
		16'h3200, 16'h3300, 16'h3400, 16'h3500, 16'h5B00, 16'h5C10, 16'h5D20
	};
	localparam logic [7:0]  TOUCH_0_VAL = 8'h5A;
	localparam logic [7:0]  TOUCH_1_VAL = 8'hC3; // high nibble must not show up
	localparam logic [11:0] EXP_TOUCH   = {TOUCH_1_VAL[3:0], TOUCH_0_VAL};

	logic                 i_CLK = 1'b0;
	logic                 i_RST;
	touch_pkg::rx_word_t  rx;
	logic                 rx_valid;
	logic                 tx_ready = 1'b0;
	touch_pkg::bus_rsp_t  bus_rsp = '0;
	logic                 init_set;
	touch_pkg::tx_frame_t tx;
	logic                 tx_valid;
	touch_pkg::bus_req_t  bus_req;
	logic [11:0]          touch;
	logic                 chip_set;
	logic                 run_set;
	logic                 err_flag;

	logic [31:0] lfsr = 32'h8c8d;
	logic [15:0] wr_log [$];       // every bridge write, {addr, data}
	int          busy_left = 0;
	int          touch_count = 0;  // touch frames taken by the host
	int          reg_count = 0;    // register replies taken by the host
	logic [7:0]  exp_addr = 8'h00; // address of the read in flight
	logic        fail_on_read = 1'b0;
	logic        stall = 1'b0;     // hold ready low
	logic        err_seen = 1'b0;

	always #4 i_CLK = ~i_CLK; // 8 ns period

	touch_top dut_i (
		.i_CLK (i_CLK), .i_RST (i_RST), .i_rx (rx), .i_rx_valid (rx_valid),
		.i_tx_ready (tx_ready), .i_bus_rsp (bus_rsp), .i_init_set (init_set),
		.o_tx (tx), .o_tx_valid (tx_valid), .o_bus_req (bus_req), .o_touch (touch),
		.o_chip_set (chip_set), .o_run_set (run_set), .o_error (err_flag)
	);

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	task automatic fail_now(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// one-cycle command word
	task automatic send_cmd(input touch_pkg::host_op_e op, input logic [7:0] arg);
		@(negedge i_CLK);
		rx       = '{op: op, arg: arg};
		rx_valid = 1'b1;
		@(negedge i_CLK);
		rx_valid = 1'b0;
	endtask

	// ================================================
	// host ready, frame monitor and bridge model
	// ================================================
	always @(negedge i_CLK) begin
		logic b0;
		logic b1;
		b0 = lfsr_bit();
		b1 = lfsr_bit();
		tx_ready = !stall && (b0 || b1); // about three cycles in four
		if (tx_valid)
			assert (chip_set) else fail_now("frame offered before setup finished");
		if (tx_valid && tx_ready) begin // taken on the coming edge
			case (tx.tag)
				8'hBB: begin
					assert (tx.payload == {4'h0, EXP_TOUCH, 8'h00})
						else fail_now($sformatf("bad touch frame %h", tx));
					assert (touch == EXP_TOUCH)
						else fail_now($sformatf("o_touch is %h", touch));
					touch_count++;
				end
				8'h6D: begin
					assert (tx.payload == {exp_addr, exp_addr ^ 8'hA5, 8'h00})
						else fail_now($sformatf("bad register reply %h", tx));
					reg_count++;
				end
				default: fail_now($sformatf("frame with unknown tag %h", tx.tag));
			endcase
		end
		if (err_seen)
			assert (err_flag) else fail_now("error flag dropped");
		err_seen = err_seen || err_flag;

		// bridge, busy for 1 to 4 cycles after each enable
		if (bus_req.wr_en || bus_req.rd_en) begin
			b0 = lfsr_bit();
			b1 = lfsr_bit();
			busy_left    = 1 + (b1 ? 2 : 0) + (b0 ? 1 : 0);
			bus_rsp.busy = 1'b1;
			bus_rsp.fail = bus_req.rd_en && fail_on_read;
			if (bus_req.addr == 8'h00)
				bus_rsp.rdata = TOUCH_0_VAL;
			else if (bus_req.addr == 8'h01)
				bus_rsp.rdata = TOUCH_1_VAL;
			else
				bus_rsp.rdata = bus_req.addr ^ 8'hA5;
			if (bus_req.wr_en)
				wr_log.push_back({bus_req.addr, bus_req.wdata});
		end else if (busy_left > 1)
			busy_left--;
		else
			bus_rsp.busy = 1'b0;
	end

	// ================================================
	// stimulus
	// ================================================
	initial begin
		int                   base;
		touch_pkg::tx_frame_t held;
		i_RST    = 1'b1;
		rx       = '0;
		rx_valid = 1'b0;
		init_set = 1'b0;
		repeat (8) @(negedge i_CLK);
		i_RST = 1'b0;
		repeat (4) @(negedge i_CLK);

		init_set = 1'b1; // setup table
		do @(negedge i_CLK); while (!chip_set);
		assert (wr_log.size() == 14)
			else fail_now($sformatf("%0d setup writes seen", wr_log.size()));
		foreach (SETUP_WRITES[k])
			assert (wr_log[k] == SETUP_WRITES[k])
				else fail_now($sformatf("setup write %0d is %h", k, wr_log[k]));

		wr_log.delete(); // run, then a few touch frames
		send_cmd(touch_pkg::OP_RUN, 8'h00);
		do @(negedge i_CLK); while (!run_set);
		assert (wr_log.size() == 1 && wr_log[0] == 16'h5E8F)
			else fail_now("run did not write ELE_RUN exactly once");
		base = touch_count;
		while (touch_count < base + 4) @(posedge i_CLK);

		@(posedge i_CLK); // back-pressure
		stall = 1'b1;
		do @(negedge i_CLK); while (!tx_valid);
		held = tx;
		repeat (6) begin
			@(negedge i_CLK);
			assert (tx_valid && tx == held) else fail_now("frame moved while ready was low");
		end
		base = touch_count;
		@(posedge i_CLK);
		stall = 1'b0;
		while (touch_count <= base) @(posedge i_CLK);

		wr_log.delete(); // stop
		send_cmd(touch_pkg::OP_STOP, 8'h00);
		do @(negedge i_CLK); while (run_set);
		assert (wr_log.size() == 1 && wr_log[0] == 16'h5E00)
			else fail_now("stop did not write ELE_STOP exactly once");
		@(posedge i_CLK);
		base = touch_count;
		repeat (50) @(posedge i_CLK);
		assert (touch_count <= base + 1) else fail_now("touch frames went on after stop");

		exp_addr = 8'h2D; // single register read
		base = reg_count;
		send_cmd(touch_pkg::OP_READ_REG, exp_addr);
		while (reg_count <= base) @(posedge i_CLK);
		repeat (40) @(posedge i_CLK);
		assert (reg_count == base + 1) else fail_now("register read answered more than once");

		fail_on_read = 1'b1; // failing read, then a good one
		exp_addr = 8'h33;
		base = reg_count;
		send_cmd(touch_pkg::OP_READ_REG, exp_addr);
		do @(negedge i_CLK); while (!err_flag);
		fail_on_read = 1'b0;
		repeat (20) @(posedge i_CLK);
		assert (reg_count == base) else fail_now("failed read still sent a reply");
		send_cmd(touch_pkg::OP_STOP, 8'h00);
		exp_addr = 8'h41;
		send_cmd(touch_pkg::OP_READ_REG, exp_addr);
		while (reg_count <= base) @(posedge i_CLK);
		assert (err_flag) else fail_now("error flag cleared by later commands");

		$display("TEST PASSED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_CLK);
		$display("timeout: the DUT stopped answering before the tests were done");
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: build.f
source/touch_pkg.sv
source/host_cmd_regs.sv
source/touch_xfer.sv
source/touch_sequencer.sv
source/tx_framer.sv
source/touch_top.sv
dv/touch_props.sv
dv/touch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the touch controller testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module touch_tb -f build.f -o sim_touch
./obj_dir/sim_touch 2>&1 | tee sim.log
if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"
